// ==== Makefile ====
# Verilator build and run of the neuron pair testbench

VERILATOR ?= verilator
TOP       ?= izh_pair_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps

.PHONY: sim clean

# Exit status of the simulation binary is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/izh_pair_sva.sv ====
`timescale 1ns/100ps
`default_nettype none

module izh_pair_sva (
    input logic       clock_i,
    input logic       reset_i,
    input logic [1:0] req_i,                        // Client requests
    input logic [1:0] ack_i                         // Server acknowledges
);

    //////////////////////////////
    // Four-phase handshake
    //////////////////////////////

    for (genvar g = 0; g < 2; g++) begin : g_client
        a_req_hold: assert property (@(posedge clock_i) disable iff (reset_i)
            req_i[g] && !ack_i[g] |=> req_i[g])     // No withdrawal before ack
            else $error("Client %0d dropped req before ack", g);

        a_ack_needs_req: assert property (@(posedge clock_i) disable iff (reset_i)
            $rose(ack_i[g]) |-> req_i[g])
            else $error("Client %0d got ack without req", g);

        a_ack_fall: assert property (@(posedge clock_i) disable iff (reset_i)
            $fell(ack_i[g]) |-> !$past(req_i[g]))   // Release closes the cycle
            else $error("Client %0d ack fell while req was high", g);
    end

    a_one_ack: assert property (@(posedge clock_i) disable iff (reset_i) !(&ack_i))
        else $error("Both clients acknowledged at once");

endmodule

bind izh_mult_server izh_pair_sva u_sva (
    .clock_i (clock_i),
    .reset_i (reset_i),
    .req_i   (req_i),
    .ack_i   (ack_o)
);

`default_nettype wire

// ==== include/izh_ref_model.svh ====
`ifndef IZH_REF_MODEL_SVH
`define IZH_REF_MODEL_SVH

// Reference multiply, exact 4.32 product cut back to 2.16
function automatic izh_pkg::fix_t ref_mul(input izh_pkg::fix_t a, input izh_pkg::fix_t b);
    longint      prod;
    logic [35:0] bits;
    prod = longint'(a) * longint'(b);               // Exact signed product
    bits = prod[35:0];                              // 4.32 view of it
    return {bits[35], bits[32:16]};                 // Sign plus bits 32..16
endfunction

// Drive widened to 2.16, less the inhibition when the other neuron spiked
function automatic izh_pkg::fix_t ref_current(input logic [15:0] drive,
                                              input logic other_spike);
    izh_pkg::fix_t cur;
    cur = {2'b00, drive};
    if (other_spike) begin
        cur = cur - izh_pkg::INHIBIT_CUR;
    end
    return cur;
endfunction

// One neuron step with spike and reset
function automatic izh_pkg::neuron_state_t ref_step(input izh_pkg::neuron_state_t s,
                                                    input izh_pkg::fix_t cur,
                                                    input izh_pkg::fix_t rate);
    izh_pkg::fix_t v;
    izh_pkg::fix_t u;
    izh_pkg::fix_t sq;
    izh_pkg::fix_t bv;
    izh_pkg::fix_t du;
    izh_pkg::neuron_state_t n;
    v = s.v;
    u = s.u;
    if (v > izh_pkg::V_PEAK) begin                  // Spike step
        n.v     = izh_pkg::C_RESET;
        n.u     = u + izh_pkg::D_COEF;
        n.spike = 1'b1;
    end else begin
        sq      = ref_mul(v, v);
        bv      = ref_mul(v, izh_pkg::B_COEF);
        du      = ref_mul(bv - u, rate);
        n.v     = v + ((sq + v + (v >>> 2) + (izh_pkg::C14 >>> 2)
                        - (u >>> 2) + (cur >>> 2)) >>> 2);
        n.u     = u + (du >>> 4);
        n.spike = 1'b0;
    end
    return n;
endfunction

`endif

// ==== bench/izh_pair_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module izh_pair_tb;

    import izh_pkg::*;

    `include "izh_ref_model.svh"

    localparam int STEP_DIV    = 64;
    localparam int ZERO_STEPS  = 40;                // Drive held at zero
    localparam int RAND_STEPS  = 400;               // Random drive runs
    localparam int AFTER_STEPS = 60;                // After the mid-run reset
    localparam int TOTAL_STEPS = ZERO_STEPS + RAND_STEPS + AFTER_STEPS;

    logic          clock;
    logic          reset;
    logic [15:0]   drive;
    neuron_state_t state [2];
    logic          step_done;

    neuron_state_t model [2];                       // Expected neuron states
    logic [15:0]   held_drive;                      // Drive the next tick will sample
    integer        seed;
    int            cyc;                             // Cycles since reset release
    int            steps;                           // Steps since reset release
    int            inhib_steps;                     // Steps run on a reduced current
    logic [1:0]    spike_seen;

    izh_pair_top #(.STEP_DIV(STEP_DIV)) dut (
        .clock_i     (clock),
        .reset_i     (reset),
        .drive_i     (drive),
        .state_o     (state),
        .step_done_o (step_done)
    );

    //////////////////////////////
    // Clock, cycle count, watchdog
    //////////////////////////////

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;                  // 8 ns period
    end

    always @(posedge clock) begin
        cyc <= reset ? 0 : cyc + 1;                 // Edge 1 is the first out of reset
    end

    initial begin
        repeat (TOTAL_STEPS * STEP_DIV * 2) @(posedge clock);
        $display("Watchdog expired before all steps finished");
        $display("Test failed");
        $fatal(1, "Timeout");
    end

    //////////////////////////////
    // Checks
    //////////////////////////////

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check_state(input string name, input neuron_state_t exp,
                               input neuron_state_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: expected v=%h u=%h spike=%b, actual v=%h u=%h spike=%b",
                     name, exp.v, exp.u, exp.spike, act.v, act.u, act.spike);
            $display("Test failed");
            $fatal(1, "State mismatch");
        end
    endtask

    // Window index of a pulse against the step it should close
    task automatic check_done(input string name, input int window, input int step);
        if (window < step) begin
            abort_run($sformatf("%s: doubled step pulse, step %0d came in window %0d",
                                name, step, window));
        end else if (window > step) begin
            abort_run($sformatf("%s: missing step pulse, step %0d came in window %0d",
                                name, step, window));
        end
    endtask

    //////////////////////////////
    // Stimulus and model
    //////////////////////////////

    task automatic wait_done(input string name);
        int waited;
        waited = 0;
        @(negedge clock);                           // Outputs settled mid-cycle
        while (step_done !== 1'b1) begin
            waited++;
            if (waited > 2 * STEP_DIV) begin
                abort_run($sformatf("%s: no step pulse after step %0d", name, steps));
            end
            @(negedge clock);
        end
        steps++;
        check_done(name, (cyc - 1) / STEP_DIV, steps);
    endtask

    task automatic advance_model(input string name);
        fix_t          cur [2];
        neuron_state_t prev [2];
        prev = model;
        for (int i = 0; i < 2; i++) begin
            cur[i] = ref_current(held_drive, prev[1-i].spike); // Last step's spikes
            if (prev[1-i].spike && prev[i].v <= V_PEAK) begin
                inhib_steps++;                      // Reduced current reaches v
            end
        end
        model[0] = ref_step(prev[0], cur[0], A_FAST);
        model[1] = ref_step(prev[1], cur[1], A_SLOW);
        spike_seen |= {model[1].spike, model[0].spike};
        for (int i = 0; i < 2; i++) begin
            check_state($sformatf("%s n%0d step %0d", name, i, steps), model[i], state[i]);
        end
    endtask

    task automatic run_steps(input string name, input int count, input bit rand_drive);
        int run_left;
        run_left = 0;
        repeat (count) begin
            wait_done(name);
            advance_model(name);
            if (rand_drive) begin
                if (run_left == 0) begin            // New value for 1 to 20 steps
                    run_left   = 1 + int'($unsigned($random(seed)) % 20);
                    held_drive = 16'($random(seed));
                end
                run_left--;
            end
            @(posedge clock);
            drive <= held_drive;                    // Well before the next tick
        end
    endtask

    task automatic apply_reset();
        @(posedge clock);
        reset <= 1'b1;
        drive <= 16'h0000;
        repeat (5) @(posedge clock);
        reset <= 1'b0;
        held_drive = 16'h0000;
        steps      = 0;
        for (int i = 0; i < 2; i++) begin
            model[i] = '{v: V_INIT, u: U_INIT, spike: 1'b0};
        end
        @(negedge clock);
        check_state("reset n0", model[0], state[0]);
        check_state("reset n1", model[1], state[1]);
        if (step_done !== 1'b0) begin
            abort_run("Step pulse high straight after reset");
        end
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        seed        = 32'h8b86_d928;
        reset       = 1'b1;
        drive       = 16'h0000;
        held_drive  = 16'h0000;
        inhib_steps = 0;
        spike_seen  = 2'b00;
        apply_reset();
        run_steps("zero drive", ZERO_STEPS, 1'b0);
        spike_seen = 2'b00;
        run_steps("random drive", RAND_STEPS, 1'b1);
        if (spike_seen != 2'b11) begin
            abort_run("A neuron never spiked under random drive");
        end
        apply_reset();                              // Mid-run reset, model restarts
        run_steps("after reset", AFTER_STEPS, 1'b1);
        if (inhib_steps == 0) begin
            abort_run("No step ran on an inhibited current");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
verilog/izh_pkg.sv
verilog/izh_neuron.sv
verilog/izh_mult_server.sv
verilog/izh_pair_top.sv
bench/izh_pair_sva.sv
bench/izh_pair_tb.sv

// ==== verilog/izh_mult_server.sv ====
`timescale 1ns/100ps
`default_nettype none

module izh_mult_server (
    input  logic               clock_i,
    input  logic               reset_i,
    input  logic [1:0]         req_i,               // One request per client
    input  izh_pkg::mult_req_t op_i [2],            // Operands per client
    output logic [1:0]         ack_o,               // One acknowledge per client
    output izh_pkg::fix_t      prod_o               // Shared product bus
);

    import izh_pkg::*;

    //////////////////////////////
    // Declarations
    //////////////////////////////

    typedef enum logic [1:0] {
        S_IDLE,                                     // Free, looking at requests
        S_MUL,                                      // Granted, product being registered
        S_ACK                                       // ack high, waiting for req to drop
    } fsm_e;

    fsm_e       fsm_q;
    logic       grant_q;                            // Client being served
    logic       last_q;                             // Client served most recently
    logic [1:0] ack_q;
    fix_t       prod_q;
    logic       pick;                               // Winner among current requests

    //////////////////////////////
    // Round-robin pick
    //////////////////////////////

    // On a tie the client not served last wins
    always_comb begin
        if (req_i[0] && req_i[1]) begin
            pick = ~last_q;
        end else begin
            pick = req_i[1];                        // Lone requester, or don't care
        end
    end

    //////////////////////////////
    // Handshake FSM
    //////////////////////////////

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            fsm_q   <= S_IDLE;
            grant_q <= 1'b0;
            last_q  <= 1'b1;                        // Client 0 first on a tie
            ack_q   <= 2'b00;
        end else begin
            case (fsm_q)
                S_IDLE: begin
                    if (|req_i) begin
                        grant_q <= pick;
                        fsm_q   <= S_MUL;
                    end
                end
                S_MUL: begin
                    ack_q[grant_q] <= 1'b1;         // Rises with the product
                    last_q         <= grant_q;
                    fsm_q          <= S_ACK;
                end
                S_ACK: begin
                    if (!req_i[grant_q]) begin      // Client has taken the product
                        ack_q <= 2'b00;
                        fsm_q <= S_IDLE;
                    end
                end
                default: fsm_q <= S_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Multiplier
    //////////////////////////////

    // Operands are stable while req is held
    always_ff @(posedge clock_i) begin
        if (fsm_q == S_MUL) begin
            prod_q <= fix_mul(op_i[grant_q].op_a, op_i[grant_q].op_b);
        end
    end

    assign ack_o  = ack_q;
    assign prod_o = prod_q;                         // Held until the next grant

endmodule

`default_nettype wire

// ==== verilog/izh_neuron.sv ====
`timescale 1ns/100ps
`default_nettype none

module izh_neuron #(
    parameter izh_pkg::fix_t RECOVERY_RATE = izh_pkg::A_FAST // Per-instance a
) (
    input  logic                  clock_i,
    input  logic                  reset_i,
    input  logic                  tick_i,           // Start of a step
    input  izh_pkg::fix_t         current_i,        // Input current, sampled at tick
    output logic                  mul_req_o,        // Four-phase request
    output izh_pkg::mult_req_t    mul_op_o,         // Operands, stable while req is high
    input  logic                  mul_ack_i,        // Four-phase acknowledge
    input  izh_pkg::fix_t         mul_prod_i,       // Product, valid with ack
    output izh_pkg::neuron_state_t state_o,         // v, u and spike
    output logic                  step_done_o       // One-cycle pulse per finished step
);

    import izh_pkg::*;

    //////////////////////////////
    // Declarations
    //////////////////////////////

    typedef enum logic [1:0] {
        S_IDLE,                                     // Waiting for tick
        S_REQ,                                      // req high, waiting for ack
        S_RELEASE                                   // req low, waiting for ack to drop
    } fsm_e;

    localparam logic [1:0] PH_SQ = 2'd0;            // v * v
    localparam logic [1:0] PH_BV = 2'd1;            // v * b
    localparam logic [1:0] PH_DU = 2'd2;            // (b*v - u) * a

    fsm_e          fsm_q;
    logic [1:0]    phase_q;                         // Which multiply is in flight
    neuron_state_t st_q;
    logic          done_q;

    fix_t          cur_q;                           // Current latched at tick
    fix_t          sq_q;                            // v squared
    fix_t          bv_q;                            // b times v
    fix_t          du_q;                            // a times (b*v - u)

    fix_t          v_now;
    fix_t          u_now;
    fix_t          bv_minus_u;
    fix_t          v_next;
    fix_t          u_next;
    logic          fire;

    //////////////////////////////
    // Datapath
    //////////////////////////////

    assign v_now      = st_q.v;                     // Signed views of the state
    assign u_now      = st_q.u;
    assign bv_minus_u = bv_q - u_now;
    assign fire       = v_now > V_PEAK;             // Spike decision at tick

    // Euler step, dt = 1/16
    // v' = v + (v^2 + 5/4 v + 1.40/4 - u/4 + I/4) / 4
    assign v_next = v_now + ((sq_q + v_now + (v_now >>> 2) + (C14 >>> 2)
                              - (u_now >>> 2) + (cur_q >>> 2)) >>> 2);
    // u' = u + a (b v - u) / 16
    assign u_next = u_now + (du_q >>> 4);

    // Operand select per phase
    always_comb begin
        case (phase_q)
            PH_SQ:   mul_op_o = '{op_a: v_now, op_b: v_now};
            PH_BV:   mul_op_o = '{op_a: v_now, op_b: B_COEF};
            default: mul_op_o = '{op_a: bv_minus_u, op_b: RECOVERY_RATE};
        endcase
    end

    assign mul_req_o   = (fsm_q == S_REQ);          // Held until ack is seen
    assign state_o     = st_q;
    assign step_done_o = done_q;

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            fsm_q   <= S_IDLE;
            phase_q <= PH_SQ;
            st_q    <= '{v: V_INIT, u: U_INIT, spike: 1'b0};
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;                         // Pulse by default
            case (fsm_q)
                S_IDLE: begin
                    if (tick_i) begin
                        if (fire) begin             // Spike step, no multiplies
                            st_q.v     <= C_RESET;
                            st_q.u     <= u_now + D_COEF;
                            st_q.spike <= 1'b1;
                            done_q     <= 1'b1;
                        end else begin
                            phase_q <= PH_SQ;
                            fsm_q   <= S_REQ;
                        end
                    end
                end
                S_REQ: begin
                    if (mul_ack_i) begin            // Product captured below
                        fsm_q <= S_RELEASE;
                    end
                end
                S_RELEASE: begin
                    if (!mul_ack_i) begin           // Handshake closed
                        if (phase_q == PH_DU) begin
                            st_q   <= '{v: v_next, u: u_next, spike: 1'b0};
                            done_q <= 1'b1;
                            fsm_q  <= S_IDLE;
                        end else begin
                            phase_q <= phase_q + 2'd1;
                            fsm_q   <= S_REQ;
                        end
                    end
                end
                default: fsm_q <= S_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Operand and product registers
    //////////////////////////////

    always_ff @(posedge clock_i) begin
        if (fsm_q == S_IDLE && tick_i) begin
            cur_q <= current_i;
        end
        if (fsm_q == S_REQ && mul_ack_i) begin
            case (phase_q)
                PH_SQ:   sq_q <= mul_prod_i;
                PH_BV:   bv_q <= mul_prod_i;
                default: du_q <= mul_prod_i;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/izh_pair_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module izh_pair_top #(
    parameter int unsigned STEP_DIV = 4096          // Cycles per step
) (
    input  logic                   clock_i,
    input  logic                   reset_i,
    input  logic [15:0]            drive_i,         // Unsigned fraction, both neurons
    output izh_pkg::neuron_state_t state_o [2],     // States after the last step
    output logic                   step_done_o      // Pulse when both neurons are done
);

    import izh_pkg::*;

    // Period never below the worst-case step
    localparam int unsigned PERIOD = (STEP_DIV < MIN_STEP_DIV) ? MIN_STEP_DIV : STEP_DIV;
    localparam int          CNT_W  = $clog2(PERIOD);

    //////////////////////////////
    // Declarations
    //////////////////////////////

    logic [CNT_W-1:0] cnt_q;                        // Step divider
    logic             tick_q;
    fix_t             drive_fix;
    fix_t             nrn_cur [2];                  // Current after inhibition
    neuron_state_t    nrn_state [2];
    logic [1:0]       nrn_done;
    logic [1:0]       mul_req;
    logic [1:0]       mul_ack;
    mult_req_t        mul_op [2];
    fix_t             mul_prod;
    logic [1:0]       seen_q;                       // Sticky step-done bits
    logic [1:0]       seen_next;
    neuron_state_t    state_q [2];
    logic             done_q;

    //////////////////////////////
    // Step divider
    //////////////////////////////

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            cnt_q  <= '0;
            tick_q <= 1'b0;
        end else if (cnt_q == CNT_W'(PERIOD - 1)) begin
            cnt_q  <= '0;
            tick_q <= 1'b1;                         // One cycle every PERIOD
        end else begin
            cnt_q  <= cnt_q + 1'b1;
            tick_q <= 1'b0;
        end
    end

    assign drive_fix = {2'b00, drive_i};            // 0.16 into 2.16

    //////////////////////////////
    // Neurons
    //////////////////////////////

    for (genvar g = 0; g < 2; g++) begin : g_neuron
        // Other neuron's spike from its last step
        assign nrn_cur[g] = drive_fix - (nrn_state[1-g].spike ? INHIBIT_CUR : fix_t'(0));

        izh_neuron #(
            .RECOVERY_RATE (g == 0 ? A_FAST : A_SLOW)
        ) u_neuron (
            .clock_i     (clock_i),
            .reset_i     (reset_i),
            .tick_i      (tick_q),
            .current_i   (nrn_cur[g]),
            .mul_req_o   (mul_req[g]),
            .mul_op_o    (mul_op[g]),
            .mul_ack_i   (mul_ack[g]),
            .mul_prod_i  (mul_prod),
            .state_o     (nrn_state[g]),
            .step_done_o (nrn_done[g])
        );
    end

    izh_mult_server u_mult_server (
        .clock_i (clock_i),
        .reset_i (reset_i),
        .req_i   (mul_req),
        .op_i    (mul_op),
        .ack_o   (mul_ack),
        .prod_o  (mul_prod)
    );

    //////////////////////////////
    // Step-done join
    //////////////////////////////

    assign seen_next = seen_q | nrn_done;

    always_ff @(posedge clock_i) begin
        if (reset_i) begin
            seen_q <= 2'b00;
            done_q <= 1'b0;
            for (int i = 0; i < 2; i++) begin
                state_q[i] <= '{v: V_INIT, u: U_INIT, spike: 1'b0};
            end
        end else if (&seen_next) begin             // Later neuron just finished
            seen_q  <= 2'b00;
            done_q  <= 1'b1;
            state_q <= nrn_state;
        end else begin
            seen_q <= seen_next;
            done_q <= 1'b0;
        end
    end

    assign state_o     = state_q;
    assign step_done_o = done_q;

endmodule

`default_nettype wire

// ==== verilog/izh_pkg.sv ====
`default_nettype none

package izh_pkg;

    //////////////////////////////
    // Fixed-point format
    //////////////////////////////

    localparam int FIX_W = 18;                          // Sign, 1 integer bit, 16 fraction bits

    typedef logic signed [FIX_W-1:0] fix_t;             // 2.16 signed word

    //////////////////////////////
    // Model constants
    //////////////////////////////

    localparam fix_t V_PEAK      = 18'sh0_4CCC;         // 0.3 spike threshold
    localparam fix_t V_INIT      = 18'sh3_4CCD;         // -0.7 membrane at reset
    localparam fix_t U_INIT      = 18'sh3_CCCD;         // -0.2 recovery at reset
    localparam fix_t C14         = 18'sh1_6666;         // 1.40 constant term
    localparam fix_t B_COEF      = 18'sh0_3333;         // 0.2 recovery sensitivity
    localparam fix_t C_RESET     = 18'sh3_8000;         // -0.5 membrane after spike
    localparam fix_t D_COEF      = 18'sh0_051E;         // 0.02 recovery kick on spike
    localparam fix_t A_FAST      = 18'sh0_051E;         // 0.02 recovery rate
    localparam fix_t A_SLOW      = 18'sh0_041E;         // Just under 0.02
    localparam fix_t INHIBIT_CUR = 18'sh0_8000;         // 0.5 taken off by the other spike

    localparam int MIN_STEP_DIV = 32;                   // Worst-case step fits in this

    //////////////////////////////
    // Bundles
    //////////////////////////////

    // Operand pair for one multiply
    typedef struct packed {
        fix_t op_a;                                     // Multiplicand
        fix_t op_b;                                     // Multiplier
    } mult_req_t;

    // Visible state of one neuron
    typedef struct packed {
        fix_t v;                                        // Membrane voltage
        fix_t u;                                        // Recovery variable
        logic spike;                                    // Set for the step after a spike
    } neuron_state_t;

    //////////////////////////////
    // Arithmetic
    //////////////////////////////

    // 2.16 product, full 4.32 result cut back to 2.16
    function automatic fix_t fix_mul(input fix_t a, input fix_t b);
        logic signed [2*FIX_W-1:0] full;
        full = a * b;                                   // Signed 36-bit product
        return {full[2*FIX_W-1], full[2*FIX_W-4:FIX_W-2]}; // Sign plus bits 32..16
    endfunction

endpackage

`default_nettype wire
